// File: Makefile
# Verilator build and run of the flush subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_flush_subsys
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
PASS_MSG  ?= Test passed

.PHONY: sim clean

# Exit status comes from the search for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: include/tb_flush_cases.svh
// Flush decode table
// Event masks and one row per case with the flush vector that the decode rules give

`ifndef TB_FLUSH_CASES_SVH
`define TB_FLUSH_CASES_SVH

// Event strobe masks, one bit per pipeline event
localparam logic [9:0] EV_BR_VALID = 10'h001;
localparam logic [9:0] EV_MISPRED  = 10'h002;
localparam logic [9:0] EV_FENCE    = 10'h004;
localparam logic [9:0] EV_FENCE_I  = 10'h008;
localparam logic [9:0] EV_SFENCE   = 10'h010;
localparam logic [9:0] EV_CSR      = 10'h020;
localparam logic [9:0] EV_COMMIT   = 10'h040;
localparam logic [9:0] EV_EX       = 10'h080;
localparam logic [9:0] EV_ERET     = 10'h100;
localparam logic [9:0] EV_DEBUG    = 10'h200;

localparam int NUM_CASES = 14;

string case_name [NUM_CASES] = '{
    "mispredict", "mispredict no valid", "fence", "fence.i", "sfence.vma",
    "csr flush", "commit flush", "exception", "eret", "debug entry",
    "exception + fence", "debug + fence.i", "eret + sfence.vma", "mispredict + csr"
};

logic [9:0] case_ev [NUM_CASES] = '{
    EV_BR_VALID | EV_MISPRED, EV_MISPRED, EV_FENCE, EV_FENCE_I, EV_SFENCE,
    EV_CSR, EV_COMMIT, EV_EX, EV_ERET, EV_DEBUG,
    EV_EX | EV_FENCE, EV_DEBUG | EV_FENCE_I, EV_ERET | EV_SFENCE,
    EV_BR_VALID | EV_MISPRED | EV_CSR
};

// Bit order MSB first
// set_pc_commit, if, unissued, id, ex, bp, icache, tlb
flush_pkg::flush_vec_t case_exp [NUM_CASES] = '{
    8'b0110_0000, 8'b0000_0000, 8'b1111_1000, 8'b1111_1010, 8'b1111_1001,
    8'b1111_1000, 8'b1111_1000, 8'b0111_1100, 8'b0111_1100, 8'b0111_1100,
    8'b0111_1100, 8'b0111_1110, 8'b0111_1101, 8'b1111_1000
};

`endif

// File: bench/tb_flush_subsys.sv
// Flush subsystem testbench
// Table-driven flush decode checks plus cache flush and accelerator fence scenarios

`timescale 1ns/1ps

module tb_flush_subsys;

    import flush_pkg::*;

    localparam int HALF_PERIOD = 10;
    // Outputs are sampled mid-cycle, well away from both edges
    localparam int SETTLE      = 5;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        halt_csr_i;
    logic        eret_i;
    logic        ex_valid_i;
    logic        set_debug_pc_i;
    bp_resolve_t resolved_branch_i;
    logic        flush_csr_i;
    logic        fence_i_i;
    logic        fence_i;
    logic        sfence_vma_i;
    logic        flush_commit_i;
    logic        mark_dirty_i;
    line_idx_t   mark_idx_i;
    logic        wb_ready_i;
    logic        wb_valid_o;
    line_idx_t   wb_idx_o;
    logic        acc_issue_i;
    logic        acc_done_i;
    flush_vec_t  flush_o;
    logic        halt_o;

    `include "tb_flush_cases.svh"

    // Cycle budget per row and for the scenarios, doubled as margin
    localparam int ROW_CYCLES  = 30;
    localparam int SCEN_CYCLES = 400;
    localparam int WATCHDOG_NS = (NUM_CASES * ROW_CYCLES + SCEN_CYCLES) * 4 * HALF_PERIOD;

    int          err_cnt = 0;
    int          test_cnt = 0;
    int          test_fail = 0;
    int          err_base = 0;
    int          cycles;
    logic [31:0] rng_state = 32'd94;
    logic [15:0] exp_dirty;
    line_idx_t   wb_seen [$];
    line_idx_t   exp_q [$];

    flush_subsys_top dut_i (.*);

    always #(HALF_PERIOD) clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // One summary line per finished test
    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt != err_base) begin
            test_fail++;
            $display("%-22s FAIL, %0d errors", name, err_cnt - err_base);
        end else begin
            $display("%-22s ok", name);
        end
        err_base = err_cnt;
    endtask

    task automatic drive_events(input logic [9:0] ev);
        resolved_branch_i.valid          = |(ev & EV_BR_VALID);
        resolved_branch_i.pc             = 32'h8000_0040;
        resolved_branch_i.target_address = 32'h8000_0100;
        resolved_branch_i.is_taken       = 1'b0;
        resolved_branch_i.is_mispredict  = |(ev & EV_MISPRED);
        fence_i        = |(ev & EV_FENCE);
        fence_i_i      = |(ev & EV_FENCE_I);
        sfence_vma_i   = |(ev & EV_SFENCE);
        flush_csr_i    = |(ev & EV_CSR);
        flush_commit_i = |(ev & EV_COMMIT);
        ex_valid_i     = |(ev & EV_EX);
        eret_i         = |(ev & EV_ERET);
        set_debug_pc_i = |(ev & EV_DEBUG);
    endtask

    // Called at the mid-cycle sample point
    task automatic wait_halt_low(output int n);
        n = 0;
        while (halt_o) begin
            @(negedge clk_i);
            #(SETTLE);
            n++;
        end
    endtask

    // Fence, then record every write-back handshake until halt drops
    task automatic run_fence(input bit stall);
        @(negedge clk_i);
        fence_i = 1'b1;
        @(negedge clk_i);
        fence_i = 1'b0;
        #(SETTLE);
        check("fence raises halt", 32'd1, 32'(halt_o));
        while (halt_o) begin
            @(negedge clk_i);
            rng_state  = xorshift32(rng_state);
            wb_ready_i = stall ? (rng_state[1:0] != 2'b00) : 1'b1;
            #(SETTLE);
            if (wb_valid_o && wb_ready_i) wb_seen.push_back(wb_idx_o);
        end
        check("valid low after halt", 32'd0, 32'(wb_valid_o));
        @(negedge clk_i);
        wb_ready_i = 1'b1;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_ni       = 1'b0;
        halt_csr_i   = 1'b0;
        mark_dirty_i = 1'b0;
        mark_idx_i   = '0;
        wb_ready_i   = 1'b1;
        acc_issue_i  = 1'b0;
        acc_done_i   = 1'b0;
        drive_events('0);
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;

        // ------------------------------------------------------------------
        // Reset state and an empty fence
        // ------------------------------------------------------------------
        #(SETTLE);
        check("reset halt", 32'd0, 32'(halt_o));
        check("reset wb valid", 32'd0, 32'(wb_valid_o));
        run_fence(1'b0);
        check("reset fence writes", 32'd0, 32'(wb_seen.size()));
        end_test("after reset");

        // ------------------------------------------------------------------
        // Decode table
        // ------------------------------------------------------------------
        for (int i = 0; i < NUM_CASES; i++) begin
            @(negedge clk_i);
            drive_events(case_ev[i]);
            #(SETTLE);
            check(case_name[i], 32'(case_exp[i]), 32'(flush_o));
            @(negedge clk_i);
            drive_events('0);
            #(SETTLE);
            // Fence rows keep the engine busy for a scan
            wait_halt_low(cycles);
            end_test(case_name[i]);
        end

        // ------------------------------------------------------------------
        // Dirty lines written back under stalls
        // ------------------------------------------------------------------
        exp_dirty = '0;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk_i);
            rng_state    = xorshift32(rng_state);
            mark_dirty_i = 1'b1;
            mark_idx_i   = rng_state[7:4];
            exp_dirty[rng_state[7:4]] = 1'b1;
        end
        @(negedge clk_i);
        mark_dirty_i = 1'b0;
        wb_seen.delete();
        run_fence(1'b1);
        for (int i = 0; i < 16; i++) begin
            if (exp_dirty[i]) exp_q.push_back(line_idx_t'(i));
        end
        check("wb count", 32'(exp_q.size()), 32'(wb_seen.size()));
        if (exp_q.size() == wb_seen.size()) begin
            for (int i = 0; i < exp_q.size(); i++) begin
                check($sformatf("wb order %0d", i), 32'(exp_q[i]), 32'(wb_seen[i]));
            end
        end
        // All lines are clean now
        wb_seen.delete();
        run_fence(1'b1);
        check("second fence writes", 32'd0, 32'(wb_seen.size()));
        end_test("dirty write-back");

        // ------------------------------------------------------------------
        // Accelerator stores hold a fence.i
        // ------------------------------------------------------------------
        repeat (3) begin
            @(negedge clk_i);
            acc_issue_i = 1'b1;
        end
        @(negedge clk_i);
        acc_issue_i = 1'b0;
        fence_i_i   = 1'b1;
        @(negedge clk_i);
        fence_i_i = 1'b0;
        repeat (30) begin
            @(negedge clk_i);
            #(SETTLE);
            check("halt held for stores", 32'd1, 32'(halt_o));
        end
        for (int i = 0; i < 3; i++) begin
            @(negedge clk_i);
            acc_done_i = 1'b1;
            #(SETTLE);
            check("halt before last done", 32'd1, 32'(halt_o));
            @(negedge clk_i);
            acc_done_i = 1'b0;
            #(SETTLE);
        end
        wait_halt_low(cycles);
        check("halt release cycles", 32'd1, 32'(cycles));
        end_test("accelerator fence.i");

        @(negedge clk_i);
        halt_csr_i = 1'b1;
        #(SETTLE);
        check("csr halt", 32'd1, 32'(halt_o));
        check("csr halt no flush", 32'd0, 32'(flush_o));
        @(negedge clk_i);
        halt_csr_i = 1'b0;
        #(SETTLE);
        check("csr halt release", 32'd0, 32'(halt_o));
        end_test("csr halt");

        $display("tests %0d, failed %0d, mismatches %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
src/flush_pkg.sv
src/acc_store_tracker.sv
src/dcache_flush_engine.sv
src/flush_ctrl.sv
src/flush_subsys_top.sv
bench/tb_flush_subsys.sv

// File: src/acc_store_tracker.sv
// Accelerator store tracker
// Counts stores issued to the accelerator that have not completed yet

`timescale 1ns/1ps

module acc_store_tracker (
    input  logic clk_i,
    input  logic rst_ni,
    // Store handed to the accelerator
    input  logic issue_i,
    // Accelerator retired a store
    input  logic done_i,
    output logic pending_o
);

    import flush_pkg::*;

    acc_cnt_t cnt_d, cnt_q;

    // Up/down count, simultaneous issue and done cancel out
    always_comb begin
        unique case ({issue_i, done_i})
            2'b10:   cnt_d = cnt_q + acc_cnt_t'(1);
            2'b01:   cnt_d = cnt_q - acc_cnt_t'(1);
            default: cnt_d = cnt_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    assign pending_o = (cnt_q != '0);

    // Completion never arrives for a store that was not issued
    no_underflow_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (done_i && !issue_i) |-> (cnt_q != '0)
    ) else $error("accelerator store count underflow");

    // Issue logic must respect the counter capacity
    no_overflow_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (issue_i && !done_i) |-> (cnt_q != '1)
    ) else $error("accelerator store count overflow");

endmodule

// File: src/dcache_flush_engine.sv
// Data cache flush engine
// Tracks dirty lines and writes them back in index order on a flush request

`timescale 1ns/1ps

module dcache_flush_engine (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // Flush request, level until acknowledged
    input  logic                 flush_i,
    // Store hit marks a line dirty
    input  logic                 mark_dirty_i,
    input  flush_pkg::line_idx_t mark_idx_i,
    input  logic                 wb_ready_i,
    output logic                 flush_ack_o,
    output logic                 wb_valid_o,
    output flush_pkg::line_idx_t wb_idx_o
);

    import flush_pkg::*;

    dfl_state_t             state_d, state_q;
    line_idx_t              idx_d, idx_q;
    logic [NUM_LINES-1:0]   dirty_d, dirty_q;
    logic                   last_line;

    assign last_line = (idx_q == line_idx_t'(NUM_LINES - 1));

    // ------------------------------------------------------------------
    // Write-back channel
    // ------------------------------------------------------------------
    // A dirty line is offered in its first scan cycle, WB only holds a stall
    assign wb_valid_o  = ((state_q == DFL_SCAN) && dirty_q[idx_q]) || (state_q == DFL_WB);
    assign wb_idx_o    = idx_q;
    assign flush_ack_o = (state_q == DFL_ACK);

    // ------------------------------------------------------------------
    // Scan FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        dirty_d = dirty_q;

        unique case (state_q)
            DFL_IDLE: begin
                // Dirty tracking only while no flush runs
                if (mark_dirty_i) begin
                    dirty_d[mark_idx_i] = 1'b1;
                end
                if (flush_i) begin
                    state_d = DFL_SCAN;
                    idx_d   = '0;
                end
            end

            DFL_SCAN: begin
                if (dirty_q[idx_q] && !wb_ready_i) begin
                    // Memory stalls, park on this line
                    state_d = DFL_WB;
                end else begin
                    // Clean line skipped, or dirty line accepted this cycle
                    dirty_d[idx_q] = 1'b0;
                    if (last_line) begin
                        state_d = DFL_ACK;
                    end else begin
                        idx_d = idx_q + line_idx_t'(1);
                    end
                end
            end

            DFL_WB: begin
                if (wb_ready_i) begin
                    dirty_d[idx_q] = 1'b0;
                    if (last_line) begin
                        state_d = DFL_ACK;
                    end else begin
                        state_d = DFL_SCAN;
                        idx_d   = idx_q + line_idx_t'(1);
                    end
                end
            end

            DFL_ACK: begin
                // One-cycle acknowledge, request drops the cycle after
                state_d = DFL_IDLE;
            end

            default: begin
                state_d = DFL_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= DFL_IDLE;
            idx_q   <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            idx_q   <= idx_d;
            dirty_q <= dirty_d;
        end
    end

    // Offered line must not change under back-pressure
    wb_hold_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (wb_valid_o && !wb_ready_i) |=> (wb_valid_o && $stable(wb_idx_o))
    ) else $error("write-back index changed while stalled");

endmodule

// File: src/flush_ctrl.sv
// Flush controller
// Decodes pipeline events into flush strobes, tracks fences and drives the core halt

`timescale 1ns/1ps

module flush_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Halt request from CSR file (WFI)
    input  logic                   halt_csr_i,
    // Exception return
    input  logic                   eret_i,
    // Exception taken at commit
    input  logic                   ex_valid_i,
    // Debug mode entry
    input  logic                   set_debug_pc_i,
    input  flush_pkg::bp_resolve_t resolved_branch_i,
    // CSR write with side effect
    input  logic                   flush_csr_i,
    input  logic                   fence_i_i,
    input  logic                   fence_i,
    input  logic                   sfence_vma_i,
    // Flush request from commit stage
    input  logic                   flush_commit_i,
    // Data cache flush handshake
    input  logic                   flush_dcache_ack_i,
    // Accelerator still has stores in flight
    input  logic                   acc_store_pending_i,
    output flush_pkg::flush_vec_t  flush_o,
    output logic                   flush_dcache_o,
    output logic                   halt_o
);

    import flush_pkg::*;

    // High from fence until the data cache acknowledges
    logic fence_active_d, fence_active_q;
    // High from fence until the accelerator has drained its stores
    logic wait_acc_store_d, wait_acc_store_q;
    // Next value of the registered cache flush request
    logic flush_dcache_d;

    // ------------------------------------------------------------------
    // Event decoding
    // ------------------------------------------------------------------
    // Later events in this block override earlier ones
    always_comb begin
        fence_active_d   = fence_active_q;
        wait_acc_store_d = wait_acc_store_q;
        flush_dcache_d   = 1'b0;
        flush_o          = '0;

        // Mispredict only kills the front end
        if (resolved_branch_i.valid && resolved_branch_i.is_mispredict) begin
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
        end

        // Fence behaves like a CSR side effect plus a cache flush
        if (fence_i) begin
            flush_o.set_pc_commit  = 1'b1;
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
            flush_o.flush_id       = 1'b1;
            flush_o.flush_ex       = 1'b1;
            wait_acc_store_d       = 1'b1;
            if (DCACHE_WRITE_BACK) begin
                flush_dcache_d = 1'b1;
                fence_active_d = 1'b1;
            end
        end

        // fence.i additionally drops the instruction cache
        if (fence_i_i) begin
            flush_o.set_pc_commit  = 1'b1;
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
            flush_o.flush_id       = 1'b1;
            flush_o.flush_ex       = 1'b1;
            flush_o.flush_icache   = 1'b1;
            wait_acc_store_d       = 1'b1;
            if (DCACHE_WRITE_BACK) begin
                flush_dcache_d = 1'b1;
                fence_active_d = 1'b1;
            end
        end

        // Accelerator has drained, release the wait
        if (wait_acc_store_q && !acc_store_pending_i) begin
            wait_acc_store_d = 1'b0;
        end

        // Hold the cache request until the engine is done
        if (DCACHE_WRITE_BACK) begin
            if (fence_active_q && flush_dcache_ack_i) begin
                fence_active_d = 1'b0;
            end else if (fence_active_q) begin
                flush_dcache_d = 1'b1;
            end
        end

        // TLB shootdown
        if (sfence_vma_i) begin
            flush_o.set_pc_commit  = 1'b1;
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
            flush_o.flush_id       = 1'b1;
            flush_o.flush_ex       = 1'b1;
            flush_o.flush_tlb      = 1'b1;
        end

        // Restart from commit PC
        if (flush_csr_i || flush_commit_i) begin
            flush_o.set_pc_commit  = 1'b1;
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
            flush_o.flush_id       = 1'b1;
            flush_o.flush_ex       = 1'b1;
        end

        // Trap, trap return and debug entry redirect through their own PC
        if (ex_valid_i || eret_i || set_debug_pc_i) begin
            flush_o.set_pc_commit  = 1'b0;
            flush_o.flush_if       = 1'b1;
            flush_o.flush_unissued = 1'b1;
            flush_o.flush_id       = 1'b1;
            flush_o.flush_ex       = 1'b1;
            // Stops speculative fetch on stale predictions after a mode change
            flush_o.flush_bp       = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Halt
    // ------------------------------------------------------------------
    always_comb begin
        halt_o = halt_csr_i || fence_active_q || wait_acc_store_q;
    end

    // ------------------------------------------------------------------
    // State registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fence_active_q   <= 1'b0;
            wait_acc_store_q <= 1'b0;
            flush_dcache_o   <= 1'b0;
        end else begin
            fence_active_q   <= fence_active_d;
            wait_acc_store_q <= wait_acc_store_d;
            // Registered to keep the cache request off the event paths
            flush_dcache_o   <= flush_dcache_d;
        end
    end

    // Engine only answers a request that this controller raised
    ack_needs_fence_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        flush_dcache_ack_i |-> fence_active_q
    ) else $error("dcache flush ack without active fence");

endmodule

// File: src/flush_pkg.sv
// Flush subsystem package
// Shared build constants, vector types, pipeline structs and the cache flush FSM encoding

package flush_pkg;

    // ------------------------------------------------------------------
    // Build constants
    // ------------------------------------------------------------------

    // Data cache policy, write-through builds never need a cache flush on fence
    localparam bit DCACHE_WRITE_BACK = 1'b1;

    // Data cache geometry
    localparam int unsigned LINE_IDX_W = 4;
    localparam int unsigned NUM_LINES  = 1 << LINE_IDX_W;

    // Outstanding accelerator store counter
    localparam int unsigned ACC_CNT_W = 4;

    // ------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------

    typedef logic [31:0]           pc_t;
    typedef logic [LINE_IDX_W-1:0] line_idx_t;
    typedef logic [ACC_CNT_W-1:0]  acc_cnt_t;

    // ------------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------------

    // Branch resolution from the execute stage
    typedef struct packed {
        logic valid;
        pc_t  pc;
        pc_t  target_address;
        logic is_taken;
        logic is_mispredict;
    } bp_resolve_t;

    // Combinational flush strobes toward the pipeline
    typedef struct packed {
        logic set_pc_commit;   // PC gen takes the PC from commit
        logic flush_if;
        logic flush_unissued;  // Scoreboard entries not yet issued
        logic flush_id;
        logic flush_ex;
        logic flush_bp;
        logic flush_icache;
        logic flush_tlb;
    } flush_vec_t;

    // Data cache flush FSM
    typedef enum logic [1:0] {
        DFL_IDLE,
        DFL_SCAN,
        DFL_WB,
        DFL_ACK
    } dfl_state_t;

endpackage

// File: src/flush_subsys_top.sv
// Flush subsystem top
// Joins the flush controller, the data cache flush engine and the accelerator tracker

`timescale 1ns/1ps

module flush_subsys_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // ------------------------------------------------------------------
    // Pipeline events
    // ------------------------------------------------------------------
    input  logic                   halt_csr_i,
    input  logic                   eret_i,
    input  logic                   ex_valid_i,
    input  logic                   set_debug_pc_i,
    input  flush_pkg::bp_resolve_t resolved_branch_i,
    input  logic                   flush_csr_i,
    input  logic                   fence_i_i,
    input  logic                   fence_i,
    input  logic                   sfence_vma_i,
    input  logic                   flush_commit_i,
    // ------------------------------------------------------------------
    // Data cache side
    // ------------------------------------------------------------------
    input  logic                   mark_dirty_i,
    input  flush_pkg::line_idx_t   mark_idx_i,
    input  logic                   wb_ready_i,
    output logic                   wb_valid_o,
    output flush_pkg::line_idx_t   wb_idx_o,
    // ------------------------------------------------------------------
    // Accelerator side
    // ------------------------------------------------------------------
    input  logic                   acc_issue_i,
    input  logic                   acc_done_i,
    // ------------------------------------------------------------------
    // Core control
    // ------------------------------------------------------------------
    output flush_pkg::flush_vec_t  flush_o,
    output logic                   halt_o
);

    // Controller to engine handshake
    logic dcache_flush_q;
    logic dcache_flush_ack;
    // Tracker to controller
    logic acc_store_pending;

    flush_ctrl i_flush_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .halt_csr_i          (halt_csr_i),
        .eret_i              (eret_i),
        .ex_valid_i          (ex_valid_i),
        .set_debug_pc_i      (set_debug_pc_i),
        .resolved_branch_i   (resolved_branch_i),
        .flush_csr_i         (flush_csr_i),
        .fence_i_i           (fence_i_i),
        .fence_i             (fence_i),
        .sfence_vma_i        (sfence_vma_i),
        .flush_commit_i      (flush_commit_i),
        .flush_dcache_ack_i  (dcache_flush_ack),
        .acc_store_pending_i (acc_store_pending),
        .flush_o             (flush_o),
        .flush_dcache_o      (dcache_flush_q),
        .halt_o              (halt_o)
    );

    dcache_flush_engine i_dcache_flush_engine (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (dcache_flush_q),
        .mark_dirty_i (mark_dirty_i),
        .mark_idx_i   (mark_idx_i),
        .wb_ready_i   (wb_ready_i),
        .flush_ack_o  (dcache_flush_ack),
        .wb_valid_o   (wb_valid_o),
        .wb_idx_o     (wb_idx_o)
    );

    acc_store_tracker i_acc_store_tracker (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .issue_i   (acc_issue_i),
        .done_i    (acc_done_i),
        .pending_o (acc_store_pending)
    );

endmodule
